// ==== rtl/mult_macros.svh ====
`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

// operand and result word width
`define MULT_XLEN 64

// command word from the reservation station
`define MULT_CMD_W 10

// reorder buffer entry count
`define MULT_ROB_SIZE 16

// tag width, one spare code above the entry count as in the issue logic
`define MULT_TAG_W ($clog2(`MULT_ROB_SIZE + 1))

// radix-4 retires two multiplier bits per step
`define MULT_ITERS (`MULT_XLEN / 2)

`endif

// ==== rtl/mult_pkg.sv ====
`default_nettype none

`include "mult_macros.svh"

package mult_pkg;

  typedef logic [`MULT_XLEN-1:0]   xlen_t;
  typedef logic [2*`MULT_XLEN-1:0] prod_t;
  // bits 2:0 select the op, bit 3 marks a word op, bits 9:4 pass through
  typedef logic [`MULT_CMD_W-1:0]  cmd_t;
  typedef logic [`MULT_TAG_W-1:0]  rob_tag_t;

  // codes 0 to 3 match the command's low three bits
  typedef enum logic [2:0] {
    MUL_LO  = 3'd0,
    MUL_HSS = 3'd1,
    MUL_HSU = 3'd2,
    MUL_HUU = 3'd3,
    MUL_W   = 3'd4
  } mul_op_e;

  typedef enum logic [1:0] {
    S_WAIT = 2'd0,
    S_BUSY = 2'd1,
    S_DONE = 2'd2
  } issue_state_e;

  typedef struct packed {
    xlen_t    op_a;
    xlen_t    op_b;
    cmd_t     cmd;
    rob_tag_t tag;
  } rs_entry_s;

  typedef struct packed {
    mul_op_e op;
    xlen_t   mag_a;
    xlen_t   mag_b;
    logic    negate;
  } mul_job_s;

  typedef struct packed {
    xlen_t    value;
    cmd_t     cmd;
    rob_tag_t tag;
  } exec_out_s;

endpackage

`default_nettype wire

// ==== rtl/mult_op_decode.sv ====
`default_nettype none

module mult_op_decode (
  input  mult_pkg::rs_entry_s job_i,
  output mult_pkg::mul_job_s  job_o
);
  import mult_pkg::*;

  localparam int unsigned XW   = $bits(xlen_t);
  localparam int unsigned HALF = XW / 2;

  mul_op_e op;
  xlen_t   src_a;
  xlen_t   src_b;
  logic    a_signed;
  logic    b_signed;
  logic    neg_a;
  logic    neg_b;

  // op kind from the command, anything unknown falls into the word op
  always_comb begin
    op = MUL_W;
    if (!job_i.cmd[3]) begin
      case (job_i.cmd[2:0])
        3'd0:    op = MUL_LO;
        3'd1:    op = MUL_HSS;
        3'd2:    op = MUL_HSU;
        3'd3:    op = MUL_HUU;
        default: op = MUL_W;
      endcase
    end
  end

  // word ops work on the sign-extended low halves
  always_comb begin
    if (op == MUL_W) begin
      src_a = {{HALF{job_i.op_a[HALF-1]}}, job_i.op_a[HALF-1:0]};
      src_b = {{HALF{job_i.op_b[HALF-1]}}, job_i.op_b[HALF-1:0]};
    end else begin
      src_a = job_i.op_a;
      src_b = job_i.op_b;
    end
  end

  // only MULHU treats rs1 as unsigned, rs2 is signed for MUL, MULH and MULW
  assign a_signed = (op != MUL_HUU);
  assign b_signed = (op == MUL_LO) || (op == MUL_HSS) || (op == MUL_W);

  assign neg_a = a_signed & src_a[XW-1];
  assign neg_b = b_signed & src_b[XW-1];

  // most negative value maps onto 2^(XW-1), still correct as unsigned
  assign job_o.op     = op;
  assign job_o.mag_a  = neg_a ? (~src_a + xlen_t'(1)) : src_a;
  assign job_o.mag_b  = neg_b ? (~src_b + xlen_t'(1)) : src_b;
  assign job_o.negate = neg_a ^ neg_b;

endmodule

`default_nettype wire

// ==== rtl/mult_radix4_core.sv ====
`default_nettype none

`include "mult_macros.svh"

module mult_radix4_core (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            restore_i,
  input  logic            start_i,
  input  mult_pkg::xlen_t a_i,
  input  mult_pkg::xlen_t b_i,
  output logic            done_o,
  output mult_pkg::prod_t prod_o
);
  import mult_pkg::*;

  localparam int unsigned ITERS = `MULT_ITERS;
  localparam int unsigned CNT_W = $clog2(ITERS + 1);

  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic             step;

  // multiplicand grows by two bits per step, multiplier shrinks
  prod_t mcand_q;
  xlen_t mplier_q;
  prod_t acc_q;
  prod_t pp;

  // last step has retired all multiplier bits
  assign done_o = busy_q && (cnt_q == CNT_W'(ITERS));
  assign step   = busy_q && !done_o;

  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (restore_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (done_o) begin
      busy_q <= 1'b0;
    end else if (step) begin
      cnt_q <= cnt_q + CNT_W'(1);
    end
  end

  // partial product for the current two multiplier bits
  always_comb begin
    case (mplier_q[1:0])
      2'd0:    pp = '0;
      2'd1:    pp = mcand_q;
      2'd2:    pp = mcand_q << 1;
      default: pp = mcand_q + (mcand_q << 1);
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      mcand_q  <= prod_t'(a_i);
      mplier_q <= b_i;
      acc_q    <= '0;
    end else if (step) begin
      acc_q    <= acc_q + pp;
      mcand_q  <= mcand_q << 2;
      mplier_q <= mplier_q >> 2;
    end
  end

  assign prod_o = acc_q;

endmodule

`default_nettype wire

// ==== rtl/mult_result_buf.sv ====
`default_nettype none

module mult_result_buf (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              done_i,
  input  mult_pkg::mul_op_e op_i,
  input  logic              negate_i,
  input  mult_pkg::prod_t   prod_i,
  output mult_pkg::xlen_t   value_o
);
  import mult_pkg::*;

  localparam int unsigned XW   = $bits(xlen_t);
  localparam int unsigned HALF = XW / 2;

  prod_t signed_prod;
  xlen_t value_d;
  xlen_t value_q;

  // restore the sign of the magnitude product
  assign signed_prod = negate_i ? (~prod_i + prod_t'(1)) : prod_i;

  always_comb begin
    case (op_i)
      MUL_LO: value_d = signed_prod[XW-1:0];
      // MULW keeps the low word and sign-extends it
      MUL_W:  value_d = {{HALF{signed_prod[HALF-1]}}, signed_prod[HALF-1:0]};
      default: value_d = signed_prod[2*XW-1:XW];
    endcase
  end

  // held until the next job completes
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      value_q <= '0;
    end else if (done_i) begin
      value_q <= value_d;
    end
  end

  assign value_o = value_q;

endmodule

`default_nettype wire

// ==== rtl/mult_issue_ctrl.sv ====
`default_nettype none

module mult_issue_ctrl (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               restore_i,
  input  logic               ready_i,
  input  logic               can_go_i,
  input  logic               done_i,
  input  mult_pkg::mul_job_s job_i,
  input  mult_pkg::cmd_t     cmd_i,
  input  mult_pkg::rob_tag_t tag_i,
  output logic               start_o,
  output logic               stall_o,
  output logic               valid_o,
  output mult_pkg::mul_job_s job_o,
  output mult_pkg::cmd_t     cmd_o,
  output mult_pkg::rob_tag_t tag_o
);
  import mult_pkg::*;

  issue_state_e state_q;
  issue_state_e state_d;
  logic         accept;

  // only an idle lane takes a new entry
  assign accept = (state_q == S_WAIT) && ready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_WAIT:  if (ready_i) state_d = S_BUSY;
      S_BUSY:  if (done_i) state_d = S_DONE;
      S_DONE:  if (can_go_i) state_d = S_WAIT;
      default: state_d = S_WAIT;
    endcase
  end

  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      state_q <= S_WAIT;
    end else if (restore_i) begin
      // flush drops the job in flight
      state_q <= S_WAIT;
    end else begin
      state_q <= state_d;
    end
  end

  // entry is only stable while ready is high, so grab it now
  always_ff @(posedge clk_i) begin
    if (accept) begin
      job_o <= job_i;
      cmd_o <= cmd_i;
      tag_o <= tag_i;
    end
  end

  assign start_o = accept;
  assign stall_o = ~accept;
  assign valid_o = (state_q == S_DONE);

endmodule

`default_nettype wire

// ==== rtl/mult_exec_stage.sv ====
`default_nettype none

module mult_exec_stage (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 restore_i,
  input  mult_pkg::rs_entry_s  rs_entry_i,
  input  logic                 ready_i,
  output logic                 stall_o,
  input  logic                 can_go_i,
  output mult_pkg::exec_out_s  exec_o,
  output logic                 valid_o
);
  import mult_pkg::*;

  mul_job_s dec_job;
  mul_job_s held_job;
  cmd_t     held_cmd;
  rob_tag_t held_tag;
  logic     start;
  logic     done;
  prod_t    prod;
  xlen_t    value;

  mult_op_decode u_decode (
    .job_i (rs_entry_i),
    .job_o (dec_job)
  );

  mult_issue_ctrl u_ctrl (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .restore_i (restore_i),
    .ready_i   (ready_i),
    .can_go_i  (can_go_i),
    .done_i    (done),
    .job_i     (dec_job),
    .cmd_i     (rs_entry_i.cmd),
    .tag_i     (rs_entry_i.tag),
    .start_o   (start),
    .stall_o   (stall_o),
    .valid_o   (valid_o),
    .job_o     (held_job),
    .cmd_o     (held_cmd),
    .tag_o     (held_tag)
  );

  // core loads its operands on the accept edge, straight from decode
  mult_radix4_core u_core (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .restore_i (restore_i),
    .start_i   (start),
    .a_i       (dec_job.mag_a),
    .b_i       (dec_job.mag_b),
    .done_o    (done),
    .prod_o    (prod)
  );

  mult_result_buf u_result (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .done_i   (done),
    .op_i     (held_job.op),
    .negate_i (held_job.negate),
    .prod_i   (prod),
    .value_o  (value)
  );

  assign exec_o = '{value: value, cmd: held_cmd, tag: held_tag};

endmodule

`default_nettype wire

// ==== bench/mult_exec_stage_chk.sv ====
`default_nettype none

`include "mult_macros.svh"

module mult_exec_stage_chk (
  input logic                clk_i,
  input logic                reset_i,
  input logic                restore_i,
  input mult_pkg::rs_entry_s rs_entry_i,
  input logic                ready_i,
  input logic                stall_o,
  input logic                can_go_i,
  input mult_pkg::exec_out_s exec_o,
  input logic                valid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  import mult_pkg::*;

  localparam int unsigned LATENCY = `MULT_ITERS + 1;

  int unsigned fail_count = 0;
  logic        accept;
  logic        pending_q;
  logic [5:0]  edges_q;
  xlen_t       exp_value_q;
  cmd_t        exp_cmd_q;
  rob_tag_t    exp_tag_q;

  // RISC-V M result from the raw operands
  function automatic xlen_t expected_value(xlen_t a, xlen_t b, cmd_t cmd);
    prod_t ext_a;
    prod_t ext_b;
    prod_t full;
    if (cmd[3] || (cmd[2:0] > 3'd3)) begin
      ext_a = {{96{a[31]}}, a[31:0]};
      ext_b = {{96{b[31]}}, b[31:0]};
      full  = ext_a * ext_b;
      return {{32{full[31]}}, full[31:0]};
    end
    // sign-extend only the operands that count as signed
    ext_a = (cmd[2:0] == 3'd3) ? {64'd0, a} : {{64{a[63]}}, a};
    ext_b = (cmd[2:0] == 3'd1) ? {{64{b[63]}}, b} : {64'd0, b};
    full  = ext_a * ext_b;
    return (cmd[2:0] == 3'd0) ? full[63:0] : full[127:64];
  endfunction

  // an idle lane takes the offer, a flush in the offer cycle takes nothing
  assign accept = ready_i && !pending_q && !restore_i;

  // job in flight or waiting for the arbiter
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
      edges_q   <= '0;
    end else if (restore_i || (valid_o && can_go_i)) begin
      pending_q <= 1'b0;
    end else if (accept) begin
      pending_q <= 1'b1;
      edges_q   <= '0;
    end else if (pending_q && (edges_q != '1)) begin
      edges_q <= edges_q + 6'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      exp_value_q <= expected_value(rs_entry_i.op_a, rs_entry_i.op_b, rs_entry_i.cmd);
      exp_cmd_q   <= rs_entry_i.cmd;
      exp_tag_q   <= rs_entry_i.tag;
    end
  end

  a_value: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o |-> (exec_o.value == exp_value_q))
    else begin
      fail_count++;
      $error("Error at %0t: exec_o.value expected %h, got %h", $time,
             $sampled(exp_value_q), $sampled(exec_o.value));
    end

  a_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o |-> ((exec_o.cmd == exp_cmd_q) && (exec_o.tag == exp_tag_q)))
    else begin
      fail_count++;
      $error("Error at %0t: exec_o.cmd/tag expected %h/%h, got %h/%h", $time,
             $sampled(exp_cmd_q), $sampled(exp_tag_q),
             $sampled(exec_o.cmd), $sampled(exec_o.tag));
    end

  a_early: assert property (@(posedge clk_i) disable iff (reset_i)
    (pending_q && (edges_q < LATENCY)) |-> !valid_o)
    else begin
      fail_count++;
      $error("Error at %0t: valid_o expected 0, got 1 only %0d edges after accept",
             $time, $sampled(edges_q));
    end

  a_late: assert property (@(posedge clk_i) disable iff (reset_i)
    (pending_q && (edges_q >= LATENCY)) |-> valid_o)
    else begin
      fail_count++;
      $error("Error at %0t: valid_o expected 1, got 0 with a result due", $time);
    end

  a_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    !pending_q |-> !valid_o)
    else begin
      fail_count++;
      $error("Error at %0t: valid_o is high with no job accepted since reset or flush",
             $time);
    end

  a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (valid_o && !can_go_i && !restore_i) |=> (valid_o && $stable(exec_o)))
    else begin
      fail_count++;
      $error("Error at %0t: result changed or valid_o dropped before the grant", $time);
    end

  // busy lane always stalls, idle lane stalls only without an offer
  a_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    stall_o == (pending_q || !ready_i))
    else begin
      fail_count++;
      $error("Error at %0t: stall_o expected %b, got %b", $time,
             $sampled(pending_q || !ready_i), $sampled(stall_o));
    end

endmodule

`default_nettype wire

// ==== bench/mult_exec_stage_tb.sv ====
`default_nettype none

`include "mult_macros.svh"

module mult_exec_stage_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import mult_pkg::*;

  localparam int unsigned     JOBS       = 300;
  localparam int unsigned     MAX_GRANT  = 7;
  localparam int unsigned     JOB_CYCLES = `MULT_ITERS + 1 + MAX_GRANT + 16;
  localparam longint unsigned TIMEOUT_NS = (16 + JOBS * JOB_CYCLES) * 100;

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic        restore_i;
  rs_entry_s   rs_entry_i;
  logic        ready_i;
  logic        stall_o;
  logic        can_go_i;
  exec_out_s   exec_o;
  logic        valid_o;

  logic [31:0] lfsr_q = 32'd97;
  xlen_t       corners [9];
  int unsigned jobs_run;
  int unsigned grants;
  int unsigned flushes;

  always #50 clk_i = ~clk_i;

  mult_exec_stage DUT (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .restore_i  (restore_i),
    .rs_entry_i (rs_entry_i),
    .ready_i    (ready_i),
    .stall_o    (stall_o),
    .can_go_i   (can_go_i),
    .exec_o     (exec_o),
    .valid_o    (valid_o)
  );

  bind mult_exec_stage mult_exec_stage_chk u_chk (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .restore_i  (restore_i),
    .rs_entry_i (rs_entry_i),
    .ready_i    (ready_i),
    .stall_o    (stall_o),
    .can_go_i   (can_go_i),
    .exec_o     (exec_o),
    .valid_o    (valid_o)
  );

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic xlen_t draw_bits(int unsigned n);
    xlen_t v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic xlen_t pick_operand();
    if (draw_bits(2) == 0) begin
      return corners[draw_bits(4) % 9];
    end
    return draw_bits(64);
  endfunction

  // op 4 is the word form with random low bits
  function automatic cmd_t directed_cmd(int unsigned op);
    cmd_t c;
    c = cmd_t'(draw_bits(10));
    if (op < 4) begin
      c[3]   = 1'b0;
      c[2:0] = 3'(op);
    end else begin
      c[3] = 1'b1;
    end
    return c;
  endfunction

  task automatic issue(input xlen_t a, input xlen_t b, input cmd_t cmd);
    @(negedge clk_i);
    rs_entry_i = '{op_a: a, op_b: b, cmd: cmd, tag: rob_tag_t'(draw_bits(5))};
    ready_i    = 1'b1;
    @(negedge clk_i);
    // station reuses its entry once released
    ready_i    = 1'b0;
    rs_entry_i = '{op_a: draw_bits(64), op_b: draw_bits(64),
                   cmd: cmd_t'(draw_bits(10)), tag: rob_tag_t'(draw_bits(5))};
    jobs_run++;
  endtask

  // arbiter model that grants after 0 to 7 cycles
  task automatic collect();
    int unsigned poke;
    int unsigned delay;
    poke  = draw_bits(1);
    delay = draw_bits(3);
    if (poke != 0) begin
      // second offer while busy
      ready_i = 1'b1;
      repeat (2) @(negedge clk_i);
      ready_i = 1'b0;
    end
    while (!valid_o) begin
      @(negedge clk_i);
    end
    repeat (delay) @(negedge clk_i);
    can_go_i = 1'b1;
    @(negedge clk_i);
    can_go_i = 1'b0;
    grants++;
  endtask

  task automatic flush_job(input bit with_ready);
    int unsigned wait_cycles;
    wait_cycles = draw_bits(6);
    if (with_ready) begin
      @(negedge clk_i);
      rs_entry_i = '{op_a: draw_bits(64), op_b: draw_bits(64),
                     cmd: cmd_t'(draw_bits(10)), tag: rob_tag_t'(draw_bits(5))};
      ready_i    = 1'b1;
      restore_i  = 1'b1;
      @(negedge clk_i);
      ready_i    = 1'b0;
      restore_i  = 1'b0;
    end else begin
      issue(pick_operand(), pick_operand(), cmd_t'(draw_bits(10)));
      repeat (wait_cycles) @(negedge clk_i);
      restore_i = 1'b1;
      @(negedge clk_i);
      restore_i = 1'b0;
    end
    // lane stays quiet past the full latency
    repeat (40) @(negedge clk_i);
    flushes++;
  endtask

  initial begin
    reset_i    = 1'b1;
    restore_i  = 1'b0;
    ready_i    = 1'b0;
    can_go_i   = 1'b0;
    rs_entry_i = '0;
    jobs_run   = 0;
    grants     = 0;
    flushes    = 0;
    corners    = '{64'h0, 64'h1, '1, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff,
                   64'h0000_0000_7fff_ffff, 64'h0000_0000_8000_0000,
                   64'hffff_ffff_8000_0000, 64'h0000_0000_ffff_ffff};
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;

    for (int op = 0; op < 5; op++) begin
      for (int i = 0; i < 9; i++) begin
        issue(corners[i], corners[(2 * i + op) % 9], directed_cmd(op));
        collect();
      end
    end
    flush_job(1'b1);
    for (int n = 0; n < 240; n++) begin
      issue(pick_operand(), pick_operand(), cmd_t'(draw_bits(10)));
      collect();
      if ((n % 27) == 13) begin
        flush_job(1'b0);
      end
    end

    repeat (4) @(negedge clk_i);
    $display("jobs %0d, granted %0d, flushed %0d, assertion failures %0d",
             jobs_run, grants, flushes, DUT.u_chk.fail_count);
    if (DUT.u_chk.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns with %0d jobs run and %0d granted",
             TIMEOUT_NS, jobs_run, grants);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+rtl
rtl/mult_pkg.sv
rtl/mult_op_decode.sv
rtl/mult_radix4_core.sv
rtl/mult_result_buf.sv
rtl/mult_issue_ctrl.sv
rtl/mult_exec_stage.sv
bench/mult_exec_stage_chk.sv
bench/mult_exec_stage_tb.sv

// ==== Bender.yml ====
package:
  name: mult_exec_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mult_pkg.sv
      - rtl/mult_op_decode.sv
      - rtl/mult_radix4_core.sv
      - rtl/mult_result_buf.sv
      - rtl/mult_issue_ctrl.sv
      - rtl/mult_exec_stage.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/mult_exec_stage_chk.sv
      - bench/mult_exec_stage_tb.sv
